//--- design/gpio_config.svh
`ifndef GPIO_CONFIG_SVH
`define GPIO_CONFIG_SVH

// bus and gpio word widths
`define GPIO_DATA_W 32
`define GPIO_ADDR_W 32

// eight output words and eight input words
`define GPIO_WORDS 8
`define GPIO_IDX_W 3

// decoded windows, each one word per 4 bytes
`define GPO_BASE 32'h0100_0000
`define GPI_BASE 32'h0100_0020

// fixed wait cycles before ready
`define WR_WAIT 2
`define RD_WAIT 3

`endif

//--- design/gpio_slave_pkg.sv
`include "gpio_config.svh"

package gpio_slave_pkg;

	////////////////////////////////////////////////////////////
	// enums
	////////////////////////////////////////////////////////////

	// access kind carried with the request
	typedef enum logic {
		op_write = 1'b0,
		op_read  = 1'b1
	} bus_op_e;

	// access controller states
	typedef enum logic [1:0] {
		st_idle,
		st_wait,
		st_resp
	} acc_state_e;

	// decoded target of an address
	typedef enum logic [1:0] {
		rgn_gpo,
		rgn_gpi,
		rgn_none
	} region_e;

	////////////////////////////////////////////////////////////
	// packed bundles
	////////////////////////////////////////////////////////////

	// request, held stable by the master while valid is high
	typedef struct packed {
		logic [`GPIO_ADDR_W-1:0] addr;
		logic [`GPIO_DATA_W-1:0] wdata;
		bus_op_e                 op;
	} bus_req_t;

	// response, only meaningful while ready is high
	typedef struct packed {
		logic [`GPIO_DATA_W-1:0] rdata;
		logic                    error;
	} bus_rsp_t;

	// word select from the decoder
	typedef struct packed {
		region_e                rgn;
		logic [`GPIO_IDX_W-1:0] idx;
	} word_sel_t;

endpackage

//--- design/bus_access_ctrl.sv
`timescale 1ns/100ps
`include "gpio_config.svh"

module bus_access_ctrl import gpio_slave_pkg::*; (
	input  logic                    BUS_agnt_vi,
	input  logic                    rst_n,
	input  logic                    valid,
	input  bus_req_t                req,
	output logic                    ready,
	output logic                    error,
	output logic                    wr_en,
	output logic                    rd_en,
	output word_sel_t               sel,
	output logic [`GPIO_DATA_W-1:0] wdata
);

	// counter wide enough for the longer wait
	localparam int cnt_w = $clog2(`RD_WAIT + 1);
	// bytes covered by one window
	localparam logic [`GPIO_ADDR_W-1:0] win_bytes =
		`GPIO_ADDR_W'(`GPIO_WORDS * (`GPIO_DATA_W / 8));

	acc_state_e              state;
	logic [cnt_w-1:0]        wait_cnt;
	logic [`GPIO_ADDR_W-1:0] gpo_off;
	logic [`GPIO_ADDR_W-1:0] gpi_off;
	logic                    aligned;
	logic                    legal;
	logic                    last_wait;
	logic                    fire;

	////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////

	// offsets wrap below the base so one compare covers both ends
	assign gpo_off = req.addr - `GPO_BASE;
	assign gpi_off = req.addr - `GPI_BASE;
	assign aligned = (req.addr[1:0] == 2'b00);

	always_comb begin
		sel.rgn = rgn_none;
		sel.idx = '0;
		if (gpo_off < win_bytes) begin
			sel.rgn = rgn_gpo;
			sel.idx = gpo_off[`GPIO_IDX_W+1:2];
		end else if (gpi_off < win_bytes) begin
			sel.rgn = rgn_gpi;
			sel.idx = gpi_off[`GPIO_IDX_W+1:2];
		end
	end

	// writes only to gpo, reads to either window
	always_comb begin
		if (req.op == op_write) begin
			legal = aligned && (sel.rgn == rgn_gpo);
		end else begin
			legal = aligned && (sel.rgn != rgn_none);
		end
	end

	////////////////////////////////////////////////////////////
	// wait state tracking
	////////////////////////////////////////////////////////////

	// last wait cycle, results land on the ready edge
	assign last_wait = (req.op == op_write) ? (wait_cnt == cnt_w'(`WR_WAIT - 1))
	                                        : (wait_cnt == cnt_w'(`RD_WAIT - 1));
	assign fire = (state == st_wait) && valid && last_wait;

	// one strobe per legal access
	assign wr_en = fire && legal && (req.op == op_write);
	assign rd_en = fire && legal && (req.op == op_read);
	assign wdata = req.wdata;

	always_ff @(posedge BUS_agnt_vi) begin
		if (!rst_n) begin
			state    <= st_idle;
			wait_cnt <= '0;
			ready    <= 1'b0;
			error    <= 1'b0;
		end else begin
			// ready is a single cycle pulse
			ready <= 1'b0;
			case (state)
				st_idle: begin
					wait_cnt <= '0;
					if (valid) begin
						state <= st_wait;
					end
				end
				st_wait: begin
					if (!valid) begin
						// master gave up, drop the access
						state <= st_idle;
					end else if (last_wait) begin
						state <= st_resp;
						ready <= 1'b1;
						error <= !legal;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				// one dead cycle before the next access
				st_resp: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

endmodule

//--- design/gpo_reg_bank.sv
`timescale 1ns/100ps
`include "gpio_config.svh"

module gpo_reg_bank import gpio_slave_pkg::*; (
	input  logic                                 BUS_agnt_vi,
	input  logic                                 rst_n,
	input  logic                                 wr_en,
	input  word_sel_t                            sel,
	input  logic [`GPIO_DATA_W-1:0]              wdata,
	output logic [`GPIO_WORDS*`GPIO_DATA_W-1:0]  gp_op,
	output logic [`GPIO_WORDS-1:0]               gp_op_valid
);

	// word 0 sits in the low bits of gp_op
	logic [`GPIO_WORDS-1:0][`GPIO_DATA_W-1:0] words;

	////////////////////////////////////////////////////////////
	// output words and update strobe
	////////////////////////////////////////////////////////////

	always_ff @(posedge BUS_agnt_vi) begin
		if (!rst_n) begin
			words       <= '0;
			gp_op_valid <= '0;
		end else begin
			// strobe lives for one cycle only
			gp_op_valid <= '0;
			// wr_en only fires for an aligned gpo write
			if (wr_en) begin
				words[sel.idx]       <= wdata;
				gp_op_valid[sel.idx] <= 1'b1;
			end
		end
	end

	// flat view for the pins
	assign gp_op = words;

endmodule

//--- design/read_data_mux.sv
`timescale 1ns/100ps
`include "gpio_config.svh"

module read_data_mux import gpio_slave_pkg::*; (
	input  logic                                BUS_agnt_vi,
	input  logic                                rst_n,
	input  logic                                rd_en,
	input  word_sel_t                           sel,
	input  logic [`GPIO_WORDS*`GPIO_DATA_W-1:0] gp_op,
	input  logic [`GPIO_WORDS*`GPIO_DATA_W-1:0] gp_ip,
	output logic [`GPIO_DATA_W-1:0]             rdata
);

	// word views of the two flat buses
	logic [`GPIO_WORDS-1:0][`GPIO_DATA_W-1:0] op_words;
	logic [`GPIO_WORDS-1:0][`GPIO_DATA_W-1:0] ip_words;

	assign op_words = gp_op;
	assign ip_words = gp_ip;

	////////////////////////////////////////////////////////////
	// read data register
	////////////////////////////////////////////////////////////

	always_ff @(posedge BUS_agnt_vi) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (rd_en) begin
			case (sel.rgn)
				// readback of the output bank
				rgn_gpo: rdata <= op_words[sel.idx];
				// input pins, sampled as they are
				rgn_gpi: rdata <= ip_words[sel.idx];
				// no legal read lands here, keep old data
				default: rdata <= rdata;
			endcase
		end
	end

endmodule

//--- design/gpio_slave_top.sv
`timescale 1ns/100ps
`include "gpio_config.svh"

module gpio_slave_top import gpio_slave_pkg::*; (
	input  logic                                BUS_agnt_vi,
	input  logic                                rst_n,
	// bus side
	input  logic                                valid,
	input  bus_req_t                            req,
	output logic                                ready,
	output bus_rsp_t                            rsp,
	// gpio pins
	output logic [`GPIO_WORDS*`GPIO_DATA_W-1:0] gp_op,
	output logic [`GPIO_WORDS-1:0]              gp_op_valid,
	input  logic [`GPIO_WORDS*`GPIO_DATA_W-1:0] gp_ip
);

	logic                    wr_en;
	logic                    rd_en;
	logic                    acc_error;
	word_sel_t               sel;
	logic [`GPIO_DATA_W-1:0] wdata;
	logic [`GPIO_DATA_W-1:0] rdata;

	////////////////////////////////////////////////////////////
	// access control and decode
	////////////////////////////////////////////////////////////

	bus_access_ctrl i_ctrl (
		.BUS_agnt_vi (BUS_agnt_vi),
		.rst_n       (rst_n),
		.valid       (valid),
		.req         (req),
		.ready       (ready),
		.error       (acc_error),
		.wr_en       (wr_en),
		.rd_en       (rd_en),
		.sel         (sel),
		.wdata       (wdata)
	);

	// output words
	gpo_reg_bank i_gpo (
		.BUS_agnt_vi (BUS_agnt_vi),
		.rst_n       (rst_n),
		.wr_en       (wr_en),
		.sel         (sel),
		.wdata       (wdata),
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid)
	);

	// readback of both windows
	read_data_mux i_rmux (
		.BUS_agnt_vi (BUS_agnt_vi),
		.rst_n       (rst_n),
		.rd_en       (rd_en),
		.sel         (sel),
		.gp_op       (gp_op),
		.gp_ip       (gp_ip),
		.rdata       (rdata)
	);

	// both fields settle on the ready edge
	assign rsp = '{rdata: rdata, error: acc_error};

endmodule

//--- tb/gpio_slave_assertions.sv
`timescale 1ns/100ps
`include "gpio_config.svh"

module gpio_slave_assertions (
	input logic                   BUS_agnt_vi,
	input logic                   rst_n,
	input logic                   valid,
	input logic                   ready,
	input logic                   wr_en,
	input logic                   rd_en,
	input logic [`GPIO_WORDS-1:0] gp_op_valid
);

	////////////////////////////////////////////////////////////
	// bus response
	////////////////////////////////////////////////////////////

	// ready is a single cycle pulse
	ready_pulse: assert property (@(posedge BUS_agnt_vi) disable iff (!rst_n)
		ready |=> !ready)
		else $error("ready high for more than one cycle");

	// master held valid up to the ready edge
	ready_after_valid: assert property (@(posedge BUS_agnt_vi) disable iff (!rst_n)
		ready |-> $past(valid))
		else $error("ready without a preceding valid");

	////////////////////////////////////////////////////////////
	// update strobe
	////////////////////////////////////////////////////////////

	strobe_onehot: assert property (@(posedge BUS_agnt_vi) disable iff (!rst_n)
		$onehot0(gp_op_valid))
		else $error("more than one gp_op_valid bit set");

	// only on the write response
	strobe_with_ready: assert property (@(posedge BUS_agnt_vi) disable iff (!rst_n)
		(|gp_op_valid) |-> ready)
		else $error("gp_op_valid outside a ready cycle");

	// sync reset clears the controls one edge later
	reset_quiet: assert property (@(posedge BUS_agnt_vi)
		!rst_n |=> (!ready && !wr_en && !rd_en && gp_op_valid == '0))
		else $error("control high during reset");

endmodule

bind gpio_slave_top gpio_slave_assertions i_asrt (
	.BUS_agnt_vi (BUS_agnt_vi),
	.rst_n       (rst_n),
	.valid       (valid),
	.ready       (ready),
	.wr_en       (wr_en),
	.rd_en       (rd_en),
	.gp_op_valid (gp_op_valid)
);

//--- tb/tb_gpio_slave.sv
`timescale 1ns/100ps
`include "gpio_config.svh"

module tb_gpio_slave import gpio_slave_pkg::*; ();

	localparam int bus_w = `GPIO_WORDS * `GPIO_DATA_W;

	// one bus access and what should come back
	typedef struct packed {
		bus_op_e                 op;
		logic [`GPIO_ADDR_W-1:0] addr;
		logic [`GPIO_DATA_W-1:0] wdata;
		logic                    abort;
		logic                    exp_err;
		logic [`GPIO_DATA_W-1:0] exp_rdata;
	} row_t;

	logic                    BUS_agnt_vi = 1'b0;
	logic                    rst_n;
	logic                    valid;
	bus_req_t                req;
	logic                    ready;
	bus_rsp_t                rsp;
	logic [bus_w-1:0]        gp_op;
	logic [`GPIO_WORDS-1:0]  gp_op_valid;
	logic [bus_w-1:0]        gp_ip;

	row_t                    rows[$];
	logic [`GPIO_DATA_W-1:0] ip_words[`GPIO_WORDS];
	logic [`GPIO_DATA_W-1:0] wr_words[`GPIO_WORDS];
	// expected gp_op after every access so far
	logic [bus_w-1:0]        shadow_op = '0;
	int                      value_errs = 0;
	int                      other_errs = 0;
	int                      cycle_cnt = 0;
	int                      cycle_limit = 0;

	gpio_slave_top i_dut (.*);

	// 40 ns period
	always #20 BUS_agnt_vi = ~BUS_agnt_vi;

	// run limit, 8 cycles per row plus reset
	always @(posedge BUS_agnt_vi) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: no end of the table after %0d cycles", cycle_cnt);
			$display("test failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic void add_row(input bus_op_e op, input logic [31:0] addr,
			input logic [31:0] wdata, input logic abort, input logic exp_err,
			input logic [31:0] exp_rdata);
		rows.push_back(row_t'{op, addr, wdata, abort, exp_err, exp_rdata});
	endfunction

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic rsp_compare(input int n, input bus_rsp_t got, input bus_rsp_t exp,
			input logic with_data);
		if (got.error !== exp.error) begin
			$display("FAIL row %0d rsp.error got %h exp %h", n, got.error, exp.error);
			value_errs++;
		end
		// rdata only counts on a legal read
		if (with_data && got.rdata !== exp.rdata) begin
			$display("FAIL row %0d rsp.rdata got %h exp %h", n, got.rdata, exp.rdata);
			value_errs++;
		end
	endtask

	task automatic latency_compare(input int n, input int got, input int exp);
		if (got != exp) begin
			$display("FAIL row %0d ready latency got %h exp %h", n, got, exp);
			value_errs++;
		end
	endtask

	task automatic gpo_compare(input int n, input logic [bus_w-1:0] got_op,
			input logic [`GPIO_WORDS-1:0] got_vld, input logic [bus_w-1:0] exp_op,
			input logic [`GPIO_WORDS-1:0] exp_vld);
		if (got_op !== exp_op) begin
			$display("FAIL row %0d gp_op got %h exp %h", n, got_op, exp_op);
			value_errs++;
		end
		if (got_vld !== exp_vld) begin
			$display("FAIL row %0d gp_op_valid got %h exp %h", n, got_vld, exp_vld);
			value_errs++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// bus master
	////////////////////////////////////////////////////////////

	task automatic run_access(input int n);
		row_t                   r;
		bus_rsp_t               exp_rsp;
		logic [bus_w-1:0]       exp_op;
		logic [`GPIO_WORDS-1:0] exp_vld;
		logic [`GPIO_IDX_W-1:0] idx;
		int                     lat;
		r = rows[n];
		exp_op = shadow_op;
		exp_vld = '0;
		// legal write, one word per 4 bytes from the base
		if (r.op == op_write && !r.exp_err) begin
			idx = r.addr[`GPIO_IDX_W+1:2];
			exp_op[idx*`GPIO_DATA_W +: `GPIO_DATA_W] = r.wdata;
			exp_vld[idx] = 1'b1;
		end
		exp_rsp = '{rdata: r.exp_rdata, error: r.exp_err};
		@(posedge BUS_agnt_vi);
		valid <= 1'b1;
		req <= '{addr: r.addr, wdata: r.wdata, op: r.op};
		// this half cycle comes before edge T
		@(negedge BUS_agnt_vi);
		lat = 0;
		do begin
			@(negedge BUS_agnt_vi);
			lat++;
		end while (!ready);
		rsp_compare(n, rsp, exp_rsp, r.op == op_read && !r.exp_err);
		latency_compare(n, lat, (r.op == op_write) ? `WR_WAIT + 1 : `RD_WAIT + 1);
		gpo_compare(n, gp_op, gp_op_valid, exp_op, exp_vld);
		shadow_op = exp_op;
		@(posedge BUS_agnt_vi);
		valid <= 1'b0;
	endtask

	// valid held for one edge only, then dropped
	task automatic run_abort(input int n);
		row_t r;
		logic seen;
		r = rows[n];
		seen = 1'b0;
		@(posedge BUS_agnt_vi);
		valid <= 1'b1;
		req <= '{addr: r.addr, wdata: r.wdata, op: r.op};
		@(posedge BUS_agnt_vi);
		valid <= 1'b0;
		repeat (`RD_WAIT + 3) begin
			@(negedge BUS_agnt_vi);
			seen = seen | ready;
		end
		if (seen) begin
			$display("row %0d: the DUT answered a request that was withdrawn", n);
			other_errs++;
		end
		gpo_compare(n, gp_op, gp_op_valid, shadow_op, '0);
	endtask

	initial begin
		logic [31:0]      seed;
		logic [bus_w-1:0] ip_vec;
		rst_n <= 1'b0;
		valid <= 1'b0;
		req <= '0;
		seed = 32'h9188_3af5;
		for (int i = 0; i < `GPIO_WORDS; i++) begin
			seed = xorshift32(seed);
			ip_words[i] = seed;
			ip_vec[i*`GPIO_DATA_W +: `GPIO_DATA_W] = seed;
		end
		gp_ip <= ip_vec;
		for (int i = 0; i < `GPIO_WORDS; i++) begin
			seed = xorshift32(seed);
			wr_words[i] = seed;
		end

		// outputs zero after reset, then write, readback, input words
		for (int i = 0; i < `GPIO_WORDS; i++)
			add_row(op_read, `GPO_BASE + 4*i, '0, 1'b0, 1'b0, '0);
		for (int i = 0; i < `GPIO_WORDS; i++)
			add_row(op_write, `GPO_BASE + 4*i, wr_words[i], 1'b0, 1'b0, '0);
		for (int i = 0; i < `GPIO_WORDS; i++)
			add_row(op_read, `GPO_BASE + 4*i, '0, 1'b0, 1'b0, wr_words[i]);
		for (int i = 0; i < `GPIO_WORDS; i++)
			add_row(op_read, `GPI_BASE + 4*i, '0, 1'b0, 1'b0, ip_words[i]);
		// illegal accesses
		add_row(op_write, `GPI_BASE + 32'h8, 32'hdead_beef, 1'b0, 1'b1, '0);
		add_row(op_write, `GPI_BASE + 32'h20, 32'h1234_5678, 1'b0, 1'b1, '0);
		add_row(op_read, 32'h0200_0000, '0, 1'b0, 1'b1, '0);
		add_row(op_read, `GPO_BASE - 32'h4, '0, 1'b0, 1'b1, '0);
		add_row(op_read, `GPO_BASE + 32'h5, '0, 1'b0, 1'b1, '0);
		add_row(op_write, `GPO_BASE + 32'h6, 32'hcafe_0001, 1'b0, 1'b1, '0);
		// withdrawn write, word 3 must keep its value
		add_row(op_write, `GPO_BASE + 32'hc, 32'h0bad_f00d, 1'b1, 1'b0, '0);
		add_row(op_read, `GPO_BASE + 32'hc, '0, 1'b0, 1'b0, wr_words[3]);
		cycle_limit = 8 * rows.size() + 50;

		repeat (10) @(posedge BUS_agnt_vi);
		rst_n <= 1'b1;
		foreach (rows[n]) begin
			if (rows[n].abort)
				run_abort(n);
			else
				run_access(n);
		end
		repeat (2) @(posedge BUS_agnt_vi);
		$display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+design
design/gpio_slave_pkg.sv
design/bus_access_ctrl.sv
design/gpo_reg_bank.sv
design/read_data_mux.sv
design/gpio_slave_top.sv
tb/gpio_slave_assertions.sv
tb/tb_gpio_slave.sv

//--- Makefile
TOP := tb_gpio_slave

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
